//--- design/tcdm_pkg.sv
// tcdm bus format shared by the wide accelerator port and the narrow memory lanes
package tcdm_pkg;

  // byte address, one word for every lane
  localparam int unsigned ADDR_W = 32;

  // wide accelerator side
  localparam int unsigned WIDE_DW = 64; // data bits of one wide transfer
  localparam int unsigned WIDE_BW = 8;  // one enable per byte of wide data

  // narrow memory side, one lane per channel
  localparam int unsigned NARROW_DW = 32;
  localparam int unsigned NARROW_BW = 4;

  // lane k sits LANE_STRIDE*k bytes above the wide address
  localparam int unsigned LANE_STRIDE = 4;

  // a 64-bit word seen either whole or as its 32-bit lanes
  // write data is sliced through lane, read data is assembled through lane
  // and both leave or enter the wide port through word
  typedef union packed {
    logic [WIDE_DW-1:0]                          word; // whole wide data word
    logic [WIDE_DW/NARROW_DW-1:0][NARROW_DW-1:0] lane; // lane 0 holds the low half
  } wide_word_u;

endpackage

//--- design/split_pkg.sv
// split configuration with channel count, queue sizing and controller state encodings
package split_pkg;

  localparam int unsigned NB_CHAN    = 2; // narrow channels behind one wide port
  localparam int unsigned FIFO_DEPTH = 2; // entries in each request and response queue

  // occupancy counters run from 0 up to FIFO_DEPTH inclusive
  localparam int unsigned CNT_W = 2;
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH); // read and write pointer width

  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);   // count of a full queue
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1); // pointer wraps after this

  // grant controller
  // GNT lets every lane follow the wide request
  // NO_GNT presents only the lanes that have not been granted yet
  typedef enum logic {
    GNT,
    NO_GNT
  } gnt_state_e;

  // response controller
  // RVALID passes complete responses straight through
  // NO_RVALID collects lane responses until every lane has one
  typedef enum logic {
    RVALID,
    NO_RVALID
  } rsp_state_e;

endpackage

//--- design/tcdm_bus_if.sv
// narrow tcdm channel carrying a request/grant path and a valid/ready response path
`timescale 1ns/1ps

interface tcdm_bus_if;

  // request path, a transfer happens when req and gnt are both high
  logic                           req;
  logic                           gnt;
  logic [tcdm_pkg::ADDR_W-1:0]    add;  // byte address of the lane word
  logic                           wen;  // high for a read, low for a write
  logic [tcdm_pkg::NARROW_BW-1:0] be;   // byte enables of the lane
  logic [tcdm_pkg::NARROW_DW-1:0] data; // write data of the lane

  // response path, a transfer happens when r_valid and r_ready are both high
  logic                           r_valid;
  logic [tcdm_pkg::NARROW_DW-1:0] r_data;
  logic                           r_ready;

  // the side that issues requests and consumes responses
  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    output r_ready,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  // the side that grants requests and produces responses
  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    input  r_ready,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

//--- design/tcdm_chan_fifo.sv
// per-channel request queue and response queue with accounting of outstanding answers
`timescale 1ns/1ps

module tcdm_chan_fifo (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  tcdm_bus_if.target    up,  // the splitter side advances in lock-step with the other lanes
  tcdm_bus_if.initiator down // the memory side advances freely
);

  // request queue storage
  logic [tcdm_pkg::ADDR_W-1:0]    add_mem  [split_pkg::FIFO_DEPTH];
  logic                           wen_mem  [split_pkg::FIFO_DEPTH];
  logic [tcdm_pkg::NARROW_BW-1:0] be_mem   [split_pkg::FIFO_DEPTH];
  logic [tcdm_pkg::NARROW_DW-1:0] data_mem [split_pkg::FIFO_DEPTH];

  // response queue storage
  logic [tcdm_pkg::NARROW_DW-1:0] rsp_mem  [split_pkg::FIFO_DEPTH];

  logic [split_pkg::PTR_W-1:0] req_wptr_q, req_rptr_q;
  logic [split_pkg::PTR_W-1:0] rsp_wptr_q, rsp_rptr_q;
  logic [split_pkg::CNT_W-1:0] req_cnt_q, rsp_cnt_q;
  logic [split_pkg::CNT_W:0]   rsp_load;  // responses held plus the one still in flight
  logic                        pending_q; // a granted request whose answer comes next cycle
  logic                        req_push, req_pop, rsp_push, rsp_pop;

  // advance a queue pointer and wrap at the last entry
  function automatic logic [split_pkg::PTR_W-1:0] ptr_inc(
    input logic [split_pkg::PTR_W-1:0] ptr
  );
    logic [split_pkg::PTR_W-1:0] nxt;
    if (ptr == split_pkg::LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign up.gnt   = up.req & (req_cnt_q != split_pkg::FULL_CNT); // accept while there is room
  assign req_push = up.req & up.gnt;

  // a new memory request is only issued when its answer is sure to find a slot
  assign rsp_load = rsp_cnt_q + pending_q;
  assign down.req = (req_cnt_q != '0) & (rsp_load < {1'b0, split_pkg::FULL_CNT});
  assign req_pop  = down.req & down.gnt;

  // head of the request queue, stable until the memory grants it
  assign down.add  = add_mem[req_rptr_q];
  assign down.wen  = wen_mem[req_rptr_q];
  assign down.be   = be_mem[req_rptr_q];
  assign down.data = data_mem[req_rptr_q];

  assign down.r_ready = 1'b1;                    // room was reserved at issue time
  assign rsp_push     = down.r_valid & down.r_ready;
  assign up.r_valid   = rsp_cnt_q != '0;
  assign up.r_data    = rsp_mem[rsp_rptr_q];
  assign rsp_pop      = up.r_valid & up.r_ready;

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      add_mem[req_wptr_q]  <= up.add;
      wen_mem[req_wptr_q]  <= up.wen;
      be_mem[req_wptr_q]   <= up.be;
      data_mem[req_wptr_q] <= up.data;
    end
    if (rsp_push) begin
      rsp_mem[rsp_wptr_q] <= down.r_data; // captured on the edge of the arrival cycle
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_wptr_q <= '0;
      req_rptr_q <= '0;
      req_cnt_q  <= '0;
      rsp_wptr_q <= '0;
      rsp_rptr_q <= '0;
      rsp_cnt_q  <= '0;
      pending_q  <= 1'b0;
    end else if (clear_i) begin
      req_wptr_q <= '0;
      req_rptr_q <= '0;
      req_cnt_q  <= '0;
      rsp_wptr_q <= '0;
      rsp_rptr_q <= '0;
      rsp_cnt_q  <= '0;
      pending_q  <= 1'b0;
    end else begin
      pending_q <= req_pop; // the memory answers exactly one cycle after its grant
      if (req_push) req_wptr_q <= ptr_inc(req_wptr_q);
      if (req_pop)  req_rptr_q <= ptr_inc(req_rptr_q);
      if (req_push & ~req_pop) begin
        req_cnt_q <= req_cnt_q + 1'b1;
      end else if (~req_push & req_pop) begin
        req_cnt_q <= req_cnt_q - 1'b1;
      end
      if (rsp_push) rsp_wptr_q <= ptr_inc(rsp_wptr_q);
      if (rsp_pop)  rsp_rptr_q <= ptr_inc(rsp_rptr_q);
      if (rsp_push & ~rsp_pop) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end else if (~rsp_push & rsp_pop) begin
        rsp_cnt_q <= rsp_cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- design/split_sync_ctrl.sv
// grant and response synchronization of the lanes that make up one wide transfer
`timescale 1ns/1ps

module split_sync_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         req_i,         // wide request, held until granted
  input  logic [split_pkg::NB_CHAN-1:0] lane_gnt_i,    // per-lane queue grant
  input  logic [split_pkg::NB_CHAN-1:0] lane_rvalid_i, // per-lane response available
  input  logic                         r_ready_i,     // wide response accepted
  output logic [split_pkg::NB_CHAN-1:0] lane_req_o,
  output logic [split_pkg::NB_CHAN-1:0] lane_rready_o,
  output logic                         all_gnt_o,     // every lane has taken the request
  output logic                         all_rvalid_o   // every lane holds a response
);

  split_pkg::gnt_state_e gnt_state_q, gnt_state_d;
  split_pkg::rsp_state_e rsp_state_q, rsp_state_d;

  logic [split_pkg::NB_CHAN-1:0] gnt_mask_q, gnt_mask_d; // lanes already granted
  logic [split_pkg::NB_CHAN-1:0] rsp_mask_q, rsp_mask_d; // lanes whose response has arrived
  logic [split_pkg::NB_CHAN-1:0] gnt_now, gnt_done, rsp_done;

  // in NO_GNT the wide request is still held, only the missing lanes see it
  assign lane_req_o = (gnt_state_q == split_pkg::GNT) ? {split_pkg::NB_CHAN{req_i}} :
                                                         {split_pkg::NB_CHAN{req_i}} & ~gnt_mask_q;

  assign gnt_now   = lane_req_o & lane_gnt_i;
  assign gnt_done  = gnt_now | ((gnt_state_q == split_pkg::NO_GNT) ? gnt_mask_q : '0);
  assign all_gnt_o = req_i & (&gnt_done);

  always_comb begin
    gnt_state_d = gnt_state_q;
    gnt_mask_d  = gnt_mask_q;
    if (all_gnt_o) begin
      gnt_state_d = split_pkg::GNT; // the last missing lane is taken so lanes follow again
      gnt_mask_d  = '0;
    end else if (req_i) begin
      gnt_state_d = split_pkg::NO_GNT;
      gnt_mask_d  = gnt_done; // remember partial progress so no lane is issued twice
    end
  end

  // lanes that already answered keep their response parked in the queue
  // the mask only adds lanes and is emptied when the set is complete
  assign rsp_done     = lane_rvalid_i |
                        ((rsp_state_q == split_pkg::NO_RVALID) ? rsp_mask_q : '0);
  assign all_rvalid_o = &rsp_done;

  // all lanes pop together, and only on the wide handshake
  assign lane_rready_o = {split_pkg::NB_CHAN{all_rvalid_o & r_ready_i}};

  always_comb begin
    rsp_state_d = rsp_state_q;
    rsp_mask_d  = '0;
    if (all_rvalid_o) begin
      rsp_state_d = split_pkg::RVALID; // the complete set is presented as one response
    end else if (|rsp_done) begin
      rsp_state_d = split_pkg::NO_RVALID; // some lanes are early so collecting goes on
      rsp_mask_d  = rsp_done;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_state_q <= split_pkg::GNT;
      gnt_mask_q  <= '0;
      rsp_state_q <= split_pkg::RVALID;
      rsp_mask_q  <= '0;
    end else if (clear_i) begin
      gnt_state_q <= split_pkg::GNT;
      gnt_mask_q  <= '0;
      rsp_state_q <= split_pkg::RVALID;
      rsp_mask_q  <= '0;
    end else begin
      gnt_state_q <= gnt_state_d;
      gnt_mask_q  <= gnt_mask_d;
      rsp_state_q <= rsp_state_d;
      rsp_mask_q  <= rsp_mask_d;
    end
  end

endmodule

//--- design/tcdm_split.sv
// splits a wide tcdm request into narrow lanes and merges the lane responses back
`timescale 1ns/1ps

module tcdm_split (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]  add_i,
  input  logic                         wen_i,
  input  logic [tcdm_pkg::WIDE_BW-1:0] be_i,
  input  logic [tcdm_pkg::WIDE_DW-1:0] data_i,
  input  logic                         r_ready_i,
  output logic                         gnt_o,
  output logic                         r_valid_o,
  output logic [tcdm_pkg::WIDE_DW-1:0] r_data_o,
  tcdm_bus_if.initiator                chan_o [split_pkg::NB_CHAN] // one lane per channel queue
);

  tcdm_pkg::wide_word_u wdata; // write data split into lanes
  tcdm_pkg::wide_word_u rdata; // read data gathered from lanes

  logic [split_pkg::NB_CHAN-1:0] lane_req;
  logic [split_pkg::NB_CHAN-1:0] lane_gnt;
  logic [split_pkg::NB_CHAN-1:0] lane_rvalid;
  logic [split_pkg::NB_CHAN-1:0] lane_rready;

  assign wdata.word = data_i;

  for (genvar k = 0; k < split_pkg::NB_CHAN; k++) begin : g_lane
    // request side of lane k
    assign chan_o[k].req  = lane_req[k];
    assign chan_o[k].add  = add_i + tcdm_pkg::ADDR_W'(k * tcdm_pkg::LANE_STRIDE);
    assign chan_o[k].wen  = wen_i; // same access type on every lane
    assign chan_o[k].be   = be_i[k*tcdm_pkg::NARROW_BW +: tcdm_pkg::NARROW_BW];
    assign chan_o[k].data = wdata.lane[k];

    // response side of lane k
    assign chan_o[k].r_ready = lane_rready[k];
    assign rdata.lane[k]     = chan_o[k].r_data;

    assign lane_gnt[k]    = chan_o[k].gnt;
    assign lane_rvalid[k] = chan_o[k].r_valid;
  end

  // controller that keeps the lanes of one wide transfer together
  split_sync_ctrl i_split_sync_ctrl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .req_i         ( req_i       ),
    .lane_gnt_i    ( lane_gnt    ),
    .lane_rvalid_i ( lane_rvalid ),
    .r_ready_i     ( r_ready_i   ),
    .lane_req_o    ( lane_req    ),
    .lane_rready_o ( lane_rready ),
    .all_gnt_o     ( gnt_o       ), // wide grant once the last lane is taken
    .all_rvalid_o  ( r_valid_o   )  // wide response once every lane has answered
  );

  // lane 0 forms the low half of the wide read data
  assign r_data_o = rdata.word;

endmodule

//--- design/tcdm_split_top.sv
// top level of the wide-to-narrow tcdm splitter with its per-channel queues
`timescale 1ns/1ps

module tcdm_split_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    clear_i,
  // wide accelerator port
  input  logic                                                    req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]                             add_i,
  input  logic                                                    wen_i,
  input  logic [tcdm_pkg::WIDE_BW-1:0]                            be_i,
  input  logic [tcdm_pkg::WIDE_DW-1:0]                            data_i,
  input  logic                                                    r_ready_i,
  output logic                                                    gnt_o,
  output logic                                                    r_valid_o,
  output logic [tcdm_pkg::WIDE_DW-1:0]                            r_data_o,
  // narrow memory channels where index k is channel k
  output logic [split_pkg::NB_CHAN-1:0]                           mem_req_o,
  output logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0]     mem_add_o,
  output logic [split_pkg::NB_CHAN-1:0]                           mem_wen_o,
  output logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_BW-1:0]  mem_be_o,
  output logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_DW-1:0]  mem_data_o,
  input  logic [split_pkg::NB_CHAN-1:0]                           mem_gnt_i,
  // the memory answers one cycle after each grant
  input  logic [split_pkg::NB_CHAN-1:0]                           mem_r_valid_i,
  input  logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_DW-1:0]  mem_r_data_i
);

  tcdm_bus_if split_chan [split_pkg::NB_CHAN] (); // splitter to queue
  tcdm_bus_if mem_chan   [split_pkg::NB_CHAN] (); // queue to memory

  tcdm_split i_tcdm_split (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .clear_i   ( clear_i    ),
    .req_i     ( req_i      ),
    .add_i     ( add_i      ),
    .wen_i     ( wen_i      ),
    .be_i      ( be_i       ),
    .data_i    ( data_i     ),
    .r_ready_i ( r_ready_i  ),
    .gnt_o     ( gnt_o      ),
    .r_valid_o ( r_valid_o  ),
    .r_data_o  ( r_data_o   ),
    .chan_o    ( split_chan )
  );

  for (genvar k = 0; k < split_pkg::NB_CHAN; k++) begin : g_chan
    tcdm_chan_fifo i_tcdm_chan_fifo (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .clear_i ( clear_i       ),
      .up      ( split_chan[k] ),
      .down    ( mem_chan[k]   )
    );

    // memory side of channel k onto the plain ports
    assign mem_req_o[k]  = mem_chan[k].req;
    assign mem_add_o[k]  = mem_chan[k].add;
    assign mem_wen_o[k]  = mem_chan[k].wen;
    assign mem_be_o[k]   = mem_chan[k].be;
    assign mem_data_o[k] = mem_chan[k].data;

    assign mem_chan[k].gnt     = mem_gnt_i[k];
    assign mem_chan[k].r_valid = mem_r_valid_i[k];
    assign mem_chan[k].r_data  = mem_r_data_i[k];
  end

endmodule

//--- verification/tcdm_split_checker.sv
// handshake rules of the tcdm splitter checked on the ports of its top level
`timescale 1ns/1ps

module tcdm_split_checker (
  input logic                                                   clk_i,
  input logic                                                   rst_ni,
  input logic                                                   clear_i,
  input logic                                                   r_ready_i,
  input logic                                                   r_valid_o,
  input logic [tcdm_pkg::WIDE_DW-1:0]                           r_data_o,
  input logic [split_pkg::NB_CHAN-1:0]                          mem_req_o,
  input logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0]    mem_add_o,
  input logic [split_pkg::NB_CHAN-1:0]                          mem_wen_o,
  input logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_BW-1:0] mem_be_o,
  input logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_DW-1:0] mem_data_o,
  input logic [split_pkg::NB_CHAN-1:0]                          mem_gnt_i
);

  for (genvar k = 0; k < split_pkg::NB_CHAN; k++) begin : g_chan
    // a memory request that is not granted comes back unchanged the next cycle
    req_held_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      mem_req_o[k] && !mem_gnt_i[k] |=> mem_req_o[k] && $stable(mem_add_o[k]) &&
      $stable(mem_wen_o[k]) && $stable(mem_be_o[k]) && $stable(mem_data_o[k]))
      else $error("memory request on channel %0d changed before its grant", k);
  end

  // the merged response waits for the accelerator without changing
  rsp_held_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else $error("wide response dropped or changed before r_ready_i");

  // nothing reaches the memory while reset holds the queues empty
  rst_quiet_a : assert property (@(posedge clk_i) !rst_ni |-> mem_req_o == '0)
    else $error("memory request issued during reset");

endmodule

bind tcdm_split_top tcdm_split_checker i_tcdm_split_checker (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .clear_i    ( clear_i    ),
  .r_ready_i  ( r_ready_i  ),
  .r_valid_o  ( r_valid_o  ),
  .r_data_o   ( r_data_o   ),
  .mem_req_o  ( mem_req_o  ),
  .mem_add_o  ( mem_add_o  ),
  .mem_wen_o  ( mem_wen_o  ),
  .mem_be_o   ( mem_be_o   ),
  .mem_data_o ( mem_data_o ),
  .mem_gnt_i  ( mem_gnt_i  )
);

//--- verification/tb_tcdm_split_top.sv
// tcdm splitter testbench driving random wide traffic against a memory model and a shadow memory
`timescale 1ns/1ps

module tb_tcdm_split_top;

  localparam int unsigned SEED    = 32'ha1b0_1d36;
  localparam int          N_TRANS = 300;
  localparam int          TIMEOUT = 300; // cycles any single wait may take

  logic                                                   clk_i, rst_ni, clear_i;
  logic                                                   req_i, wen_i, r_ready_i;
  logic [tcdm_pkg::ADDR_W-1:0]                            add_i;
  logic [tcdm_pkg::WIDE_BW-1:0]                           be_i;
  logic [tcdm_pkg::WIDE_DW-1:0]                           data_i, r_data_o;
  logic                                                   gnt_o, r_valid_o;
  logic [split_pkg::NB_CHAN-1:0]                          mem_req_o, mem_wen_o;
  logic [split_pkg::NB_CHAN-1:0]                          mem_gnt_i, mem_r_valid_i;
  logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0]    mem_add_o;
  logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_BW-1:0] mem_be_o;
  logic [split_pkg::NB_CHAN-1:0][tcdm_pkg::NARROW_DW-1:0] mem_data_o, mem_r_data_i;

  logic [31:0]   word_mem [logic [32:0]]; // memory model keyed by {channel, word address}
  logic [7:0]    shadow [logic [31:0]];   // byte view of what wide reads must return
  logic [104:0]  req_log [$];             // every wide request issued as {add, wen, be, data}
  logic [64:0]   exp_rsp [$];             // expected wide responses in order as {is_read, data}
  logic [1:0]    ans_pend;                // channels whose memory answers next cycle
  logic [1:0][31:0] ans_data;
  int            narrow_cnt [2];
  int            wide_gnt, rsp_cnt, val_errs, proto_errs;
  logic          cur_req, cur_wen, cur_clear, granted;
  logic [31:0]   cur_add;
  logic [7:0]    cur_be;
  logic [63:0]   cur_data;

  tcdm_split_top i_tcdm_split_top (.*);

  always #4 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Error %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // drive one cycle at the falling edge and observe the handshakes of the next rising edge
  task automatic step();
    logic [32:0]  key;
    logic [31:0]  word;
    logic [104:0] ent;
    logic [63:0]  exp_word;
    logic [64:0]  rsp_ent;
    @(negedge clk_i);
    mem_r_valid_i = ans_pend; // answer exactly one cycle after the grant
    mem_r_data_i  = ans_data;
    ans_pend      = '0;
    for (int k = 0; k < 2; k++) mem_gnt_i[k] = ($urandom % 100) < 70;
    r_ready_i = ($urandom % 100) >= 30;
    clear_i   = cur_clear;
    req_i     = cur_req;
    add_i     = cur_add;
    wen_i     = cur_wen;
    be_i      = cur_be;
    data_i    = cur_data;
    #1;
    for (int k = 0; k < 2; k++) begin
      if (mem_req_o[k] && mem_gnt_i[k]) begin
        if (narrow_cnt[k] >= req_log.size()) begin
          proto_errs++;
          $display("channel %0d issued a memory request that no wide request asked for", k);
        end else begin
          ent = req_log[narrow_cnt[k]]; // n-th narrow request belongs to the n-th wide one
          check_val("lane address", 64'(ent[104:73] + 32'(4 * k)), 64'(mem_add_o[k]));
          check_val("lane payload", 64'({ent[72], ent[64 + 4*k +: 4], ent[32*k +: 32]}),
                    64'({mem_wen_o[k], mem_be_o[k], mem_data_o[k]}));
        end
        key  = {k[0], mem_add_o[k]};
        word = word_mem.exists(key) ? word_mem[key] : '0;
        if (mem_wen_o[k]) begin
          ans_data[k] = word;
        end else begin
          for (int b = 0; b < 4; b++) begin
            if (mem_be_o[k][b]) word[8*b +: 8] = mem_data_o[k][8*b +: 8];
          end
          word_mem[key] = word;
          ans_data[k]   = $urandom; // write answers carry no meaning
        end
        ans_pend[k] = 1'b1;
        narrow_cnt[k]++;
      end
    end
    if (req_i && gnt_o) begin
      for (int b = 0; b < 8; b++) begin
        if (!wen_i && be_i[b]) shadow[add_i + 32'(b)] = data_i[8*b +: 8];
        exp_word[8*b +: 8] = shadow.exists(add_i + 32'(b)) ? shadow[add_i + 32'(b)] : 8'h00;
      end
      exp_rsp.push_back({wen_i, wen_i ? exp_word : 64'h0});
      wide_gnt++;
      granted = 1'b1;
    end
    if (r_valid_o && r_ready_i) begin
      if (exp_rsp.size() == 0) begin
        proto_errs++;
        $display("a wide response came back with no request waiting for it");
      end else begin
        rsp_ent = exp_rsp.pop_front();
        if (rsp_ent[64]) begin // data of a write response is ignored
          check_val("wide read data", rsp_ent[63:0], r_data_o);
        end
      end
      rsp_cnt++;
    end
  endtask

  // hold one wide request until it is granted
  task automatic issue(input logic [31:0] a, input logic w, input logic [7:0] be,
                       input logic [63:0] d);
    int t;
    cur_req  = 1'b1;
    cur_add  = a;
    cur_wen  = w;
    cur_be   = be;
    cur_data = d;
    req_log.push_back({a, w, be, d});
    granted = 1'b0;
    t = 0;
    while (!granted && t < TIMEOUT) begin
      step();
      t++;
    end
    if (!granted) begin
      proto_errs++;
      $display("wide request to address %h was never granted", a);
    end
    cur_req = 1'b0;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_rsp.size() != 0 && t < TIMEOUT) begin
      step();
      t++;
    end
    if (exp_rsp.size() != 0) begin
      proto_errs++;
      $display("%0d wide responses never arrived", exp_rsp.size());
    end
  endtask

  task automatic check_idle(input string name);
    check_val(name, 64'h0, 64'({gnt_o, r_valid_o, mem_req_o}));
  endtask

  initial begin
    int unsigned seed;
    seed = SEED;
    void'($urandom(seed));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    req_i         = 1'b0;
    add_i         = '0;
    wen_i         = 1'b0;
    be_i          = '0;
    data_i        = '0;
    r_ready_i     = 1'b0;
    mem_gnt_i     = '0;
    mem_r_valid_i = '0;
    mem_r_data_i  = '0;
    ans_pend      = '0;
    ans_data      = '0;
    narrow_cnt    = '{0, 0};
    {wide_gnt, rsp_cnt, val_errs, proto_errs} = '0;
    {cur_req, cur_wen, cur_clear, granted} = '0;
    {cur_add, cur_be, cur_data} = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) begin
      step();
      check_idle("outputs after reset");
    end
    // a window of eight wide words keeps read-after-write frequent
    for (int n = 0; n < N_TRANS; n++) begin
      issue(32'h1000 + 32'(8 * ($urandom % 8)), 1'($urandom), 8'($urandom),
            {32'($urandom), 32'($urandom)});
      repeat ($urandom % 3) step();
    end
    drain();
    cur_clear = 1'b1;
    repeat (2) begin
      step();
      check_idle("outputs during clear");
    end
    cur_clear = 1'b0;
    step();
    check_idle("outputs after clear");
    issue(32'h1008, 1'b0, 8'h5a, 64'h0123_4567_89ab_cdef);
    issue(32'h1008, 1'b1, 8'hff, 64'h0);
    drain();
    check_val("narrow requests on channel 0", 64'(req_log.size()), 64'(narrow_cnt[0]));
    check_val("narrow requests on channel 1", 64'(req_log.size()), 64'(narrow_cnt[1]));
    check_val("wide grants", 64'(req_log.size()), 64'(wide_gnt));
    check_val("wide responses", 64'(wide_gnt), 64'(rsp_cnt));
    $display("value errors: %0d, protocol errors and timeouts: %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tcdm_split_top.f
design/tcdm_pkg.sv
design/split_pkg.sv
design/tcdm_bus_if.sv
design/tcdm_chan_fifo.sv
design/split_sync_ctrl.sv
design/tcdm_split.sv
design/tcdm_split_top.sv
verification/tcdm_split_checker.sv
verification/tb_tcdm_split_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tcdm splitter testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tcdm_split_top -f tcdm_split_top.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_tcdm_split_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
